//--- logic/vram_pkg.sv
package vram_pkg;

    localparam int FRAME_WIDTH     = 64;
    localparam int FRAME_HEIGHT    = 64;
    localparam int PIXEL_BITS      = 8;
    localparam int PIXEL_ADDR_BITS = 12;  // Row times 64 plus column
    localparam int ROW_ADDR_BITS   = 6;
    localparam int ROW_BITS        = 512;

    localparam int AXI_ADDR_BITS = 16;
    localparam int AXI_DATA_BITS = 32;
    localparam int AXI_STRB_BITS = 4;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef logic [PIXEL_BITS-1:0]      pixel_t;
    typedef logic [PIXEL_ADDR_BITS-1:0] pixel_addr_t;
    typedef logic [ROW_ADDR_BITS-1:0]   row_addr_t;
    typedef logic [ROW_BITS-1:0]        row_t;  // Pixel 0 in the lowest byte

    typedef struct packed {
        logic [AXI_ADDR_BITS-1:0] addr;
        logic [1:0]               prot;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_DATA_BITS-1:0] data;
        logic [AXI_STRB_BITS-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic        en;
        pixel_addr_t addr;
        pixel_t      data;
    } pixel_write_t;

    typedef struct packed {
        logic      en;
        row_addr_t row;
    } row_read_t;

    typedef struct packed {
        pixel_t data;
        logic   line_end;
        logic   frame_end;
    } pixel_beat_t;

endpackage

//--- logic/host_pixel_writer.sv
`timescale 1ns/1ps

module host_pixel_writer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   awvalid,
    output logic                   awready,
    input  vram_pkg::axi_aw_t      aw,
    input  logic                   wvalid,
    output logic                   wready,
    input  vram_pkg::axi_w_t       w,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    output vram_pkg::pixel_write_t pix_wr
);
    import vram_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        WRITE,
        RESPOND
    } state_t;

    state_t                            state;
    logic [AXI_ADDR_BITS-1:0]          addr_q;
    logic [AXI_DATA_BITS-1:0]          data_q;
    logic [AXI_STRB_BITS-1:0]          strb_left;  // Strobe bits still to be written
    logic [AXI_STRB_BITS-1:0]          strb_next;
    logic [$clog2(AXI_STRB_BITS)-1:0]  lane;
    logic                              accept;
    logic                              in_range;
    pixel_addr_t                       base_pixel;

    assign awready = (state == IDLE);
    assign wready  = (state == IDLE);
    assign bvalid  = (state == RESPOND);

    // Address and data are only taken together
    assign accept = (state == IDLE) && awvalid && wvalid;

    assign in_range   = addr_q < AXI_ADDR_BITS'(FRAME_WIDTH * FRAME_HEIGHT);
    assign base_pixel = {addr_q[PIXEL_ADDR_BITS-1:2], 2'b00};
    assign strb_next  = strb_left & (strb_left - 1'b1);  // Drop the lowest set bit

    // Lowest remaining strobe bit picks the byte lane
    always_comb begin
        lane = '0;
        for (int i = AXI_STRB_BITS - 1; i >= 0; i--) begin
            if (strb_left[i]) lane = ($clog2(AXI_STRB_BITS))'(i);
        end
    end

    always_comb begin
        pix_wr.en   = (state == WRITE);
        pix_wr.addr = base_pixel + pixel_addr_t'(lane);
        pix_wr.data = data_q[lane*PIXEL_BITS +: PIXEL_BITS];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            bresp <= RESP_OKAY;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) state <= CHECK;
                end
                CHECK: begin
                    if (!in_range) begin
                        bresp <= RESP_SLVERR;
                        state <= RESPOND;
                    end else begin
                        bresp <= RESP_OKAY;
                        state <= (strb_left == '0) ? RESPOND : WRITE;
                    end
                end
                WRITE: begin
                    if (strb_next == '0) state <= RESPOND;
                end
                RESPOND: begin
                    if (bready) state <= IDLE;  // Channels reopen once the response is taken
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= aw.addr;
            data_q    <= w.data;
            strb_left <= w.strb;
        end else if (state == WRITE) begin
            strb_left <= strb_next;
        end
    end

endmodule

//--- logic/frame_vram.sv
`timescale 1ns/1ps

module frame_vram (
    input  logic                   clk,
    input  vram_pkg::pixel_write_t pix_wr,
    input  vram_pkg::row_read_t    row_rd,
    output vram_pkg::row_t         row_data
);
    import vram_pkg::*;

    // One byte per pixel, indexed by row times 64 plus column
    pixel_t mem [0:FRAME_WIDTH*FRAME_HEIGHT-1];

    always_ff @(posedge clk) begin
        if (pix_wr.en) begin
            mem[pix_wr.addr] <= pix_wr.data;
        end
    end

    // Whole row gathered into one word, held until the next request
    always_ff @(posedge clk) begin
        if (row_rd.en) begin
            for (int c = 0; c < FRAME_WIDTH; c++) begin
                row_data[c*PIXEL_BITS +: PIXEL_BITS] <=
                    mem[{row_rd.row, c[PIXEL_ADDR_BITS-ROW_ADDR_BITS-1:0]}];
            end
        end
    end

endmodule

//--- logic/row_scanout.sv
`timescale 1ns/1ps

module row_scanout (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  frame_start,
    output logic                  scan_busy,
    output vram_pkg::row_read_t   row_rd,
    input  vram_pkg::row_t        row_data,
    output logic                  pixel_valid,
    input  logic                  pixel_ready,
    output vram_pkg::pixel_beat_t pixel
);
    import vram_pkg::*;

    row_t                                     active;        // Remaining pixels of the current row
    logic                                     active_valid;
    logic                                     hold_full;     // row_data holds a row not yet taken
    logic [PIXEL_ADDR_BITS-ROW_ADDR_BITS-1:0] col;
    row_addr_t                                row;
    logic                                     line_end;
    logic                                     last_row;
    logic                                     take;

    assign line_end = (col == FRAME_WIDTH - 1);
    assign last_row = (row == FRAME_HEIGHT - 1);

    // The first pixel of a row comes straight from the memory output register
    assign pixel_valid = active_valid || hold_full;
    assign take        = pixel_valid && pixel_ready;

    always_comb begin
        pixel.data      = active_valid ? active[PIXEL_BITS-1:0] : row_data[PIXEL_BITS-1:0];
        pixel.line_end  = line_end;
        pixel.frame_end = line_end && last_row;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_busy    <= 1'b0;
            row_rd       <= '0;
            hold_full    <= 1'b0;
            active_valid <= 1'b0;
            col          <= '0;
            row          <= '0;
        end else begin
            row_rd.en <= 1'b0;

            if (frame_start && !scan_busy) begin
                scan_busy  <= 1'b1;
                row_rd.en  <= 1'b1;
                row_rd.row <= '0;
            end

            if (row_rd.en) hold_full <= 1'b1;  // Memory answers on this edge

            if (take) begin
                col <= col + 1'b1;
                if (!active_valid) begin
                    // Held row moves into the shift register, next row is fetched behind it
                    active_valid <= 1'b1;
                    hold_full    <= 1'b0;
                    row_rd.en    <= !last_row;
                    row_rd.row   <= row + 1'b1;
                end else if (line_end) begin
                    active_valid <= 1'b0;
                    row          <= row + 1'b1;
                    if (last_row) scan_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (!active_valid) begin
                active <= row_data >> PIXEL_BITS;
            end else begin
                active <= active >> PIXEL_BITS;
            end
        end
    end

endmodule

//--- logic/vram_frame_top.sv
`timescale 1ns/1ps

module vram_frame_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  awvalid,
    output logic                  awready,
    input  vram_pkg::axi_aw_t     aw,
    input  logic                  wvalid,
    output logic                  wready,
    input  vram_pkg::axi_w_t      w,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    input  logic                  frame_start,
    output logic                  scan_busy,
    output logic                  pixel_valid,
    input  logic                  pixel_ready,
    output vram_pkg::pixel_beat_t pixel
);
    import vram_pkg::*;

    pixel_write_t pix_wr;
    row_read_t    row_rd;
    row_t         row_data;

    host_pixel_writer u_writer (
        .clk     (clk),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .pix_wr  (pix_wr)
    );

    frame_vram u_vram (
        .clk      (clk),
        .pix_wr   (pix_wr),
        .row_rd   (row_rd),
        .row_data (row_data)
    );

    row_scanout u_scanout (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .scan_busy   (scan_busy),
        .row_rd      (row_rd),
        .row_data    (row_data),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel       (pixel)
    );

endmodule

//--- testbench/vram_frame_asserts.sv
`timescale 1ns/1ps

module vram_frame_asserts (
    input logic                  clk,
    input logic                  reset,
    input logic                  awready,
    input logic                  wready,
    input logic                  bvalid,
    input logic                  bready,
    input logic [1:0]            bresp,
    input logic                  scan_busy,
    input logic                  pixel_valid,
    input logic                  pixel_ready,
    input vram_pkg::pixel_beat_t pixel
);

    int failures = 0;  // Number of assertion failures so far

    resp_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            failures++;
            $error("bvalid or bresp changed before bready");
        end

    // A stalled beat keeps its data and flags
    beat_held: assert property (@(posedge clk) disable iff (reset)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel))
        else begin
            failures++;
            $error("pixel beat changed while pixel_ready was low");
        end

    valid_in_frame: assert property (@(posedge clk) disable iff (reset)
        pixel_valid |-> scan_busy)
        else begin
            failures++;
            $error("pixel_valid high outside of a frame");
        end

    closed_during_resp: assert property (@(posedge clk) disable iff (reset)
        bvalid |-> !awready && !wready)
        else begin
            failures++;
            $error("write channels open while a response is pending");
        end

endmodule

//--- testbench/vram_frame_tb.sv
`timescale 1ns/1ps

module vram_frame_tb;
    import vram_pkg::*;

    localparam int GOLDEN_COUNT = 28;
    localparam int FILL_WRITES  = 1024;
    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int CYCLE_LIMIT  = 4 * (FILL_WRITES * 6 + GOLDEN_COUNT * 6 + 2 * FRAME_PIXELS * 3);

    logic         clk = 1'b0;
    logic         reset;
    logic         awvalid, awready, wvalid, wready, bvalid, bready;
    axi_aw_t      aw;
    axi_w_t       w;
    logic [1:0]   bresp;
    logic         frame_start, scan_busy, pixel_valid, pixel_ready;
    pixel_beat_t  pixel;

    pixel_t       model [0:FRAME_PIXELS-1];
    logic [31:0]  golden [0:4*GOLDEN_COUNT-1];  // Four words per transaction
    logic [31:0]  lfsr_state = 32'hb792;
    int           cycle_count = 0;
    int           errors = 0;
    int           checks = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           assert_errors = 0;

    vram_frame_top uut (.*);

    bind host_pixel_writer vram_frame_asserts u_writer_asserts (
        .clk(clk), .reset(reset), .awready(awready), .wready(wready), .bvalid(bvalid),
        .bready(bready), .bresp(bresp), .scan_busy(1'b0), .pixel_valid(1'b0),
        .pixel_ready(1'b1), .pixel('0));
    bind row_scanout vram_frame_asserts u_scan_asserts (
        .clk(clk), .reset(reset), .awready(1'b0), .wready(1'b0), .bvalid(1'b0),
        .bready(1'b1), .bresp(2'b00), .scan_busy(scan_busy), .pixel_valid(pixel_valid),
        .pixel_ready(pixel_ready), .pixel(pixel));

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles, which counts as a failure", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    function logic lfsr_bit();
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'ha300_0000 : lfsr_state >> 1;
        return lfsr_state[0];
    endfunction

    function logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    task check_value(input logic [63:0] actual, input logic [63:0] expected, input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    task next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Pixel address equals byte address, one byte per pixel
    task update_model(input logic [15:0] byte_addr, input logic [31:0] wdata,
                      input logic [3:0] wstrb);
        if (byte_addr < FRAME_PIXELS) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) model[byte_addr + b] = wdata[8*b +: 8];
            end
        end
    endtask

    task axi_write(input logic [15:0] byte_addr, input logic [31:0] wdata,
                   input logic [3:0] wstrb, output logic [1:0] resp);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        aw      = '{addr: byte_addr, prot: 2'b00};
        w       = '{data: wdata, strb: wstrb};
        while (!(awready && wready)) next_cycle();
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) next_cycle();
        resp = bresp;
        next_cycle();  // bready is high, so the response goes on this edge
    endtask

    task golden_writes(input bit out_of_range);
        logic [15:0] byte_addr;
        logic [1:0]  resp;
        for (int i = 0; i < GOLDEN_COUNT; i++) begin
            byte_addr = {golden[4*i][13:0], 2'b00};
            if ((byte_addr >= FRAME_PIXELS) == out_of_range) begin
                axi_write(byte_addr, golden[4*i+1], golden[4*i+2][3:0], resp);
                check_value(resp, golden[4*i+3][1:0], $sformatf("golden %0d bresp", i));
                update_model(byte_addr, golden[4*i+1], golden[4*i+2][3:0]);
            end
        end
    endtask

    task scan_frame(input bit random_ready, input bit extra_start);
        int beat;
        bit pulsed;
        beat   = 0;
        pulsed = 0;
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
        while (beat < FRAME_PIXELS) begin
            pixel_ready = random_ready ? lfsr_bit() : 1'b1;
            frame_start = extra_start && !pulsed && beat == FRAME_PIXELS / 2;  // Should be ignored
            if (frame_start) pulsed = 1;
            if (pixel_valid && pixel_ready) begin
                check_value(pixel.data, model[beat], $sformatf("pixel %0d", beat));
                check_value(pixel.line_end, beat % FRAME_WIDTH == FRAME_WIDTH - 1, "line_end");
                check_value(pixel.frame_end, beat == FRAME_PIXELS - 1, "frame_end");
                beat++;
            end
            next_cycle();
        end
        frame_start = 1'b0;
        pixel_ready = 1'b1;
        check_value(scan_busy, 1'b0, "scan_busy after last beat");
        repeat (4) begin
            check_value(pixel_valid, 1'b0, "no beat after frame end");
            next_cycle();
        end
    endtask

    task finish_test(input string name, input int mark);
        int bound_failures;
        bound_failures = uut.u_writer.u_writer_asserts.failures
                       + uut.u_scanout.u_scan_asserts.failures;
        errors += bound_failures - assert_errors;  // Assertion failures since the last test
        assert_errors = bound_failures;
        tests_run++;
        if (errors != mark) tests_failed++;
        $display("Test %0d %s finished with %0d errors", tests_run, name, errors - mark);
    endtask

    initial begin
        logic [1:0]  resp;
        logic [1:0]  held;
        logic [31:0] data;
        logic [31:0] data2;
        int          mark;
        int          hold;
        reset = 1'b1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        aw = '0;
        w = '0;
        bready = 1'b1;
        frame_start = 1'b0;
        pixel_ready = 1'b1;
        $readmemh("testbench/vram_golden.hex", golden);
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        mark = errors;
        for (int i = 0; i < FILL_WRITES; i++) begin
            data = random_bits(32);
            axi_write(16'(i * 4), data, 4'hf, resp);
            check_value(resp, RESP_OKAY, "fill bresp");
            update_model(16'(i * 4), data, 4'hf);
        end
        finish_test("fill", mark);

        mark = errors;
        golden_writes(1'b0);
        finish_test("golden strobed writes", mark);
        mark = errors;
        golden_writes(1'b1);
        finish_test("golden out-of-range writes", mark);

        mark = errors;
        scan_frame(1'b0, 1'b0);
        finish_test("scanout with ready high", mark);
        mark = errors;
        scan_frame(1'b1, 1'b1);
        finish_test("scanout with random ready", mark);

        // Response held back while a second write waits on the channels
        mark = errors;
        data  = random_bits(32);
        data2 = random_bits(32);
        bready  = 1'b0;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        aw = '{addr: 16'h048c, prot: 2'b00};
        w  = '{data: data, strb: 4'hf};
        while (!(awready && wready)) next_cycle();
        next_cycle();
        aw = '{addr: 16'h048c, prot: 2'b00};
        w  = '{data: data2, strb: 4'b0110};
        while (!bvalid) next_cycle();
        held = bresp;
        check_value(held, RESP_OKAY, "held bresp");
        hold = 2 + random_bits(3);
        repeat (hold) begin
            next_cycle();
            check_value(bvalid, 1'b1, "bvalid under back-pressure");
            check_value(bresp, held, "bresp under back-pressure");
            check_value(awready, 1'b0, "second write taken early");
            check_value(wready, 1'b0, "second write data taken early");
        end
        bready = 1'b1;
        next_cycle();
        check_value(bvalid, 1'b0, "bvalid after response");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) next_cycle();
        check_value(bresp, RESP_OKAY, "second write bresp");
        next_cycle();
        update_model(16'h048c, data, 4'hf);
        update_model(16'h048c, data2, 4'b0110);
        scan_frame(1'b0, 1'b0);
        finish_test("response back-pressure", mark);

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- vram_frame.f
logic/vram_pkg.sv
logic/host_pixel_writer.sv
logic/frame_vram.sv
logic/row_scanout.sv
logic/vram_frame_top.sv
testbench/vram_frame_asserts.sv
testbench/vram_frame_tb.sv

//--- testbench/vram_golden.hex
// Columns: word address, write data, strobe, expected bresp (0 OKAY, 2 SLVERR)
// Word address 0400 and above lies outside the 4096 pixel frame
0000 11223344 1 0
0001 a5a5a5a5 2 0
0010 deadbeef 4 0
001f 01020304 8 0
0040 cafef00d 3 0
0055 12345678 5 0
007f 9abcdef0 6 0
0100 0f1e2d3c 9 0
0155 55aa55aa a 0
01ff 7e7e7e7e c 0
0200 c0ffee00 7 0
0233 87654321 b 0
02aa fedcba98 d 0
02fe 31415926 e 0
0300 ffffffff 0 0
0333 00000000 0 0
03ff 80808080 f 0
0000 ee00ee00 c 0
0010 00ff00ff 3 0
03c0 600dcafe 1 0
03ff 13579bdf 6 0
0400 badbadba f 2
0401 11111111 1 2
07ff 22222222 0 2
0800 33333333 c 2
1000 44444444 f 2
2abc 55555555 5 2
3fff 66666666 f 2
